// ==== filelist.f ====
+incdir+verilog
verilog/xaui_pkg.sv
verilog/xaui_tx_prbs.sv
verilog/xaui_tx_idle_fsm.sv
verilog/xaui_tx_idle_gen.sv
verilog/xaui_tx_top.sv
tests/xaui_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the XAUI transmit testbench with Verilator and runs it.
# The run passes only if the simulation prints the pass message.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module xaui_tx_tb -f filelist.f -o xaui_tx_sim &&
{
  sim_out="$(./obj_dir/xaui_tx_sim)"
  echo "$sim_out"
  echo "$sim_out" | grep -qx "Everything OK"
} &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// ==== tests/xaui_tx_tb.sv ====
`include "xaui_settings.svh"

module xaui_tx_tb import xaui_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int          NUM_RUNS   = 12;
  localparam int          MIN_A_GAP  = 16;
  localparam int unsigned SEED       = 32'ha19f394c;
  localparam logic [31:0] IDLE_COL   = {4{`XAUI_IDLE}};
  localparam xgmii_col_t  IDLE_XGMII = {IDLE_COL, 4'b1111};

  logic        clk = 1'b0;
  logic        reset;
  xgmii_col_t  col_i;
  logic        link_status_event_i;
  logic [31:0] link_status_i;
  xgmii_col_t  col_o;

  int errors     = 0;
  int total_cols = 0;
  int data_len [NUM_RUNS];
  int idle_len [NUM_RUNS];
  int event_at [NUM_RUNS]; // Idle column that carries the event, -1 for none.

  // Reference state, one column behind the DUT input.
  xgmii_col_t  prev_col;
  logic        checks_on  = 1'b0;
  logic        reset_d    = 1'b0;
  logic        reset_d2   = 1'b0;
  logic        prev2_data = 1'b0;
  logic        a_seen     = 1'b0;
  logic        last_a     = 1'b0;
  int          since_a    = 0;
  logic        q_expect   = 1'b0;
  logic [31:0] q_word     = '0;

  logic        in_data; // Column now at col_o came from data.
  logic        out_idle;
  logic        out_k;
  logic        out_r;
  logic        out_a;
  logic        out_q;
  logic [31:0] exp_data;

  always #50 clk = ~clk;

  xaui_tx_top xaui_tx_top_inst (
    .clk                 (clk),
    .reset               (reset),
    .col_i               (col_i),
    .link_status_event_i (link_status_event_i),
    .link_status_i       (link_status_i),
    .col_o               (col_o)
  );

  // Each flagged 07h byte goes out as BCh.
  function automatic logic [31:0] passthrough_data(input xgmii_col_t c);
    logic [7:0]  lane;
    logic [31:0] d;
    for (int i = 0; i < 4; i++) begin
      lane = c.data[8*i +: 8];
      d[8*i +: 8] = (c.ctrl[i] && lane == 8'h07) ? 8'hBC : lane;
    end
    return d;
  endfunction

  function automatic xgmii_col_t random_data_col();
    xgmii_col_t  c;
    logic [31:0] rnd;
    c.data = $urandom;
    rnd    = $urandom;
    for (int i = 0; i < 4; i++) begin
      if (rnd[2*i +: 2] == 2'b00) begin
        c.data[8*i +: 8] = `XAUI_IDLE;
      end
    end
    c.ctrl = rnd[11:8];
    if (c.data == IDLE_COL) begin
      c.data[7:0] = 8'h00; // Keep it a data column.
    end
    return c;
  endfunction

  task automatic plan_runs();
    total_cols = 8; // Reset and closing columns.
    for (int r = 0; r < NUM_RUNS; r++) begin
      data_len[r] = $urandom_range(24, 1);
      idle_len[r] = $urandom_range(120, 40);
      event_at[r] = -1;
      if ($urandom_range(2, 0) != 0) begin
        event_at[r] = $urandom_range(idle_len[r] - 40, 0); // Leaves 40 columns for Q.
      end
      total_cols = total_cols + data_len[r] + idle_len[r];
    end
  endtask

  task automatic drive_col(input xgmii_col_t c, input logic ev);
    col_i               = c;
    link_status_event_i = ev;
    link_status_i       = $urandom;
    @(posedge clk);
    #5;
  endtask

  assign in_data  = prev_col.data != IDLE_COL;
  assign out_idle = !reset_d && !in_data;
  assign out_k    = col_o.data == {4{`SYM_K}} && col_o.ctrl == 4'b1111;
  assign out_r    = col_o.data == {4{`SYM_R}} && col_o.ctrl == 4'b1111;
  assign out_a    = col_o.data == {4{`SYM_A}} && col_o.ctrl == 4'b1111;
  assign out_q    = col_o.ctrl == 4'b0001;

  always_comb exp_data = passthrough_data(prev_col);

  always @(posedge clk) begin
    prev_col   <= col_i;
    reset_d    <= reset;
    reset_d2   <= reset_d;
    prev2_data <= in_data;
    if (reset) begin
      checks_on <= 1'b1;
    end
    if (out_idle) begin
      a_seen  <= a_seen || out_a;
      last_a  <= out_a;
      since_a <= out_a ? 1 : since_a + 1;
      if (out_q) begin
        q_expect <= 1'b0;
      end
    end else begin
      a_seen <= 1'b0; // New idle run.
      last_a <= 1'b0;
    end
    if (link_status_event_i) begin
      q_expect <= 1'b1;
      q_word   <= link_status_i;
    end
  end

  reset_col_a: assert property (@(posedge clk) disable iff (!checks_on) reset_d |-> out_k)
    else begin
      errors = errors + 1;
      $display("Fail col_o in reset: expected %h, got %h",
               {{4{`SYM_K}}, 4'b1111}, $sampled(col_o));
    end

  data_pass_a: assert property (@(posedge clk) disable iff (!checks_on)
    !reset_d && in_data |-> col_o.data == exp_data && col_o.ctrl == prev_col.ctrl)
    else begin
      errors = errors + 1;
      $display("Fail col_o: expected %h, got %h",
               {$sampled(exp_data), $sampled(prev_col.ctrl)}, $sampled(col_o));
    end

  first_k_a: assert property (@(posedge clk) disable iff (!checks_on)
    !reset_d && !reset_d2 && !in_data && prev2_data |-> out_k)
    else begin
      errors = errors + 1;
      $display("Fail col_o after data: expected %h, got %h",
               {{4{`SYM_K}}, 4'b1111}, $sampled(col_o));
    end

  idle_code_a: assert property (@(posedge clk) disable iff (!checks_on)
    out_idle |-> out_k || out_r || out_a || out_q)
    else begin
      errors = errors + 1;
      $display("Fail col_o: got %h, not a K, R, A or Q column", $sampled(col_o));
    end

  a_gap_a: assert property (@(posedge clk) disable iff (!checks_on)
    out_idle && out_a && a_seen |-> since_a >= MIN_A_GAP)
    else begin
      errors = errors + 1;
      $display("Two A columns only %0d columns apart in one idle run", $sampled(since_a));
    end

  q_event_a: assert property (@(posedge clk) disable iff (!checks_on)
    out_idle && out_q |-> q_expect)
    else begin
      errors = errors + 1;
      $display("A Q column was sent without a link status event");
    end

  q_after_a_a: assert property (@(posedge clk) disable iff (!checks_on)
    out_idle && out_q |-> last_a)
    else begin
      errors = errors + 1;
      $display("A Q column was sent without an A column right before it");
    end

  q_word_a: assert property (@(posedge clk) disable iff (!checks_on)
    out_idle && out_q |-> col_o.data == q_word)
    else begin
      errors = errors + 1;
      $display("Fail col_o.data: expected %h, got %h", $sampled(q_word), $sampled(col_o.data));
    end

  q_in_run_a: assert property (@(posedge clk) disable iff (!checks_on)
    !reset_d && !reset_d2 && in_data && !prev2_data |-> !q_expect)
    else begin
      errors = errors + 1;
      $display("An idle run ended before the Q column of its link status event");
    end

  initial begin
    void'($urandom(SEED));
    reset               = 1'b1;
    col_i               = IDLE_XGMII;
    link_status_event_i = 1'b0;
    link_status_i       = '0;
    plan_runs();
    repeat (2) @(posedge clk);
    #5;
    reset = 1'b0;
    for (int r = 0; r < NUM_RUNS; r++) begin
      for (int j = 0; j < data_len[r]; j++) begin
        drive_col(random_data_col(), 1'b0);
      end
      for (int j = 0; j < idle_len[r]; j++) begin
        drive_col(IDLE_XGMII, j == event_at[r]);
      end
    end
    // Closing burst ends the last idle run.
    repeat (3) drive_col(random_data_col(), 1'b0);
    repeat (2) drive_col(IDLE_XGMII, 1'b0);
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    wait (total_cols > 0);
    #((total_cols + 100) * 100);
    $display("Timeout: the stimulus did not finish within %0d cycles", total_cols + 100);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== verilog/xaui_tx_top.sv ====
`include "xaui_settings.svh"

module xaui_tx_top import xaui_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  xgmii_col_t  col_i,
  input  logic        link_status_event_i,
  input  logic [31:0] link_status_i,
  output xgmii_col_t  col_o
);

  logic       code_sel;
  logic [4:0] a_space;
  xgmii_col_t gen_col;

  xaui_tx_prbs xaui_tx_prbs_inst (
    .clk        (clk),
    .reset      (reset),
    .code_sel_o (code_sel),
    .a_space_o  (a_space)
  );

  xaui_tx_idle_gen xaui_tx_idle_gen_inst (
    .clk                 (clk),
    .reset               (reset),
    .col_i               (col_i),
    .link_status_event_i (link_status_event_i),
    .link_status_i       (link_status_i),
    .code_sel_i          (code_sel),
    .a_space_i           (a_space),
    .col_o               (gen_col)
  );

  // The lanes see sync columns while in reset.
  always_ff @(posedge clk) begin
    if (reset) begin
      col_o.data <= {4{`SYM_K}};
      col_o.ctrl <= 4'b1111;
    end else begin
      col_o <= gen_col;
    end
  end

endmodule

// ==== verilog/xaui_tx_idle_gen.sv ====
`include "xaui_settings.svh"

module xaui_tx_idle_gen import xaui_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  xgmii_col_t  col_i,
  input  logic        link_status_event_i,
  input  logic [31:0] link_status_i,
  input  logic        code_sel_i,
  input  logic [4:0]  a_space_i,
  output xgmii_col_t  col_o
);

  idle_state_e state;
  idle_state_e state_nxt;
  ifg_e        ifg;
  ifg_e        ifg_nxt;
  logic        q_det;
  logic        q_det_nxt;
  logic [4:0]  a_cnt;
  logic        a_sent;
  logic [31:0] status;

  xaui_tx_idle_fsm xaui_tx_idle_fsm_inst (
    .reset         (reset),
    .code_sel_i    (code_sel_i),
    .a_cnt_i       (a_cnt),
    .state_i       (state),
    .ifg_i         (ifg),
    .q_det_i       (q_det),
    .set_q_i       (link_status_event_i),
    .col_i         (col_i),
    .link_status_i (status),
    .state_o       (state_nxt),
    .ifg_o         (ifg_nxt),
    .q_det_o       (q_det_nxt),
    .col_o         (col_o),
    .a_sent_o      (a_sent)
  );

  // Reset values come from the FSM.
  always_ff @(posedge clk) begin
    state <= state_nxt;
    ifg   <= ifg_nxt;
    q_det <= q_det_nxt;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      a_cnt <= `A_SPACE_MIN;
    end else if (a_sent) begin
      a_cnt <= a_space_i; // New random spacing.
    end else if (a_cnt != 5'd0) begin
      a_cnt <= a_cnt - 5'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (link_status_event_i) begin
      status <= link_status_i;
    end
  end

  a_reload_a: assert property (@(posedge clk) disable iff (reset)
    a_sent |=> a_cnt >= `A_SPACE_MIN && a_cnt <= `A_SPACE_MAX)
    else $error("A countdown reloaded out of range: %0d", a_cnt);

  q_clear_a: assert property (@(posedge clk) disable iff (reset)
    $fell(q_det) |-> $past(col_o.ctrl == 4'b0001 &&
                           (state == send_q || state == send_rand_q)))
    else $error("Pending status dropped without a Q column");

endmodule

// ==== verilog/xaui_tx_idle_fsm.sv ====
`include "xaui_settings.svh"

module xaui_tx_idle_fsm import xaui_pkg::*; (
  input  logic        reset,
  input  logic        code_sel_i,
  input  logic [4:0]  a_cnt_i,
  input  idle_state_e state_i,
  input  ifg_e        ifg_i,
  input  logic        q_det_i,
  input  logic        set_q_i,
  input  xgmii_col_t  col_i,
  input  logic [31:0] link_status_i,
  output idle_state_e state_o,
  output ifg_e        ifg_o,
  output logic        q_det_o,
  output xgmii_col_t  col_o,
  output logic        a_sent_o
);

  logic        got_data;
  logic        a_zero;
  logic        q_state;
  logic [31:0] pass_data;

  assign got_data = col_i.data != {4{`XAUI_IDLE}};
  assign a_zero   = a_cnt_i == 5'd0;
  assign q_state  = state_i == send_q || state_i == send_rand_q;

  // Flagged idle bytes inside a data column become K.
  always_comb begin
    pass_data = col_i.data;
    for (int i = 0; i < 4; i++) begin
      if (col_i.ctrl[i] && col_i.data[8*i +: 8] == `XAUI_IDLE) begin
        pass_data[8*i +: 8] = `SYM_K;
      end
    end
  end

  always_comb begin
    if (reset) begin
      state_o = send_rand_r;
    end else if (got_data) begin
      state_o = (ifg_i == ifg_k || a_zero) ? send_k : send_a;
    end else begin
      case (state_i)
        send_k:      state_o = send_rand_r;
        // A pending status goes out behind an A column.
        send_a:      state_o = q_det_i ? send_rand_a : send_rand_r;
        send_q:      state_o = send_rand_r;
        send_rand_r: begin
          if (a_zero) begin
            state_o = send_rand_a;
          end else begin
            state_o = code_sel_i ? send_rand_r : send_rand_k;
          end
        end
        send_rand_k: begin
          if (a_zero) begin
            state_o = send_rand_a;
          end else begin
            state_o = code_sel_i ? send_rand_r : send_rand_k;
          end
        end
        send_rand_a: begin
          if (q_det_i) begin
            state_o = send_rand_q;
          end else begin
            state_o = code_sel_i ? send_rand_r : send_rand_k;
          end
        end
        send_rand_q: state_o = code_sel_i ? send_rand_r : send_rand_k;
        default:     state_o = send_rand_r;
      endcase
    end
  end

  always_comb begin
    if (reset || state_i == send_k) begin
      ifg_o = ifg_a;
    end else if (state_i == send_a) begin
      ifg_o = ifg_k;
    end else begin
      ifg_o = ifg_i;
    end
  end

  // A new event wins over the clear.
  always_comb begin
    if (reset) begin
      q_det_o = 1'b0;
    end else if (set_q_i) begin
      q_det_o = 1'b1;
    end else if (q_state && !got_data) begin
      q_det_o = 1'b0;
    end else begin
      q_det_o = q_det_i;
    end
  end

  always_comb begin
    col_o.data = {4{`SYM_K}};
    col_o.ctrl = 4'b1111;
    if (got_data) begin
      col_o.data = pass_data;
      col_o.ctrl = col_i.ctrl;
    end else begin
      case (state_i)
        send_q, send_rand_q: begin
          col_o.data = link_status_i;
          col_o.ctrl = 4'b0001;
        end
        send_rand_r: col_o.data = {4{`SYM_R}};
        send_rand_a: col_o.data = {4{`SYM_A}};
        default:     col_o.data = {4{`SYM_K}}; // K, random K and send_a.
      endcase
    end
  end

  assign a_sent_o = !got_data && state_i == send_rand_a;

  always_comb begin
    if (!reset) begin
      legal_state_a: assert (state_i inside {send_a, send_k, send_q, send_rand_r,
                                             send_rand_k, send_rand_a, send_rand_q})
        else $error("Idle FSM in illegal state %0d", state_i);
    end
  end

endmodule

// ==== verilog/xaui_tx_prbs.sv ====
`include "xaui_settings.svh"

module xaui_tx_prbs (
  input  logic       clk,
  input  logic       reset,
  output logic       code_sel_o,
  output logic [4:0] a_space_o
);

  localparam logic [6:0] SEED = 7'h5b;

  logic [6:0] lfsr;
  logic       feedback;

  // Taps for x^7 + x^6 + 1.
  assign feedback = lfsr[6] ^ lfsr[5];

  always_ff @(posedge clk) begin
    if (reset) begin
      lfsr <= SEED;
    end else begin
      lfsr <= {lfsr[5:0], feedback};
    end
  end

  assign code_sel_o = lfsr[6]; // Picks R or K.

  // Low nibble over the minimum gives 16 to 31.
  assign a_space_o = `A_SPACE_MIN | {1'b0, lfsr[3:0]};

endmodule

// ==== verilog/xaui_pkg.sv ====
package xaui_pkg;

  // One XGMII column with one control flag per byte lane.
  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  ctrl; // Bit i flags byte lane i.
  } xgmii_col_t;

  // Code 0 is not used by the idle generator.
  typedef enum logic [2:0] {
    send_a      = 3'd1, // Gap after data, ifg was A.
    send_k      = 3'd2, // Gap after data, K forced.
    send_q      = 3'd3,
    send_rand_r = 3'd4,
    send_rand_k = 3'd5,
    send_rand_a = 3'd6,
    send_rand_q = 3'd7
  } idle_state_e;

  // Whether the next gap has to open with a K column.
  typedef enum logic {
    ifg_a = 1'b0,
    ifg_k = 1'b1
  } ifg_e;

endpackage

// ==== verilog/xaui_settings.svh ====
`ifndef XAUI_SETTINGS_SVH
`define XAUI_SETTINGS_SVH

// XGMII idle byte, seen on the input side.
`define XAUI_IDLE 8'h07

// XAUI code group bytes sent on the lanes.
`define SYM_K 8'hBC // Sync column.
`define SYM_R 8'h1C // Skip column.
`define SYM_A 8'h7C // Align column.
`define SYM_Q 8'h9C // Sequence column.

// Bounds of the A column countdown.
`define A_SPACE_MIN 5'd16
`define A_SPACE_MAX 5'd31

`endif
